// File: axi4s_pkg.sv
// Shared definitions for the AXI4-Stream pipeline.
// The RTL modules and the testbench import this package for the register slice
// mode and the default stream field widths.

package axi4s_pkg;

    // ========================================================================
    // Register slice modes
    // ========================================================================

    // Bypass is wires only with zero latency.
    // Lightweight holds one beat, so it runs at half rate.
    // Fully registered is a two-entry skid buffer that runs at full rate.
    typedef enum logic [1:0] {
        REG_SLICE_BYPASS           = 2'd0,
        REG_SLICE_LIGHTWEIGHT      = 2'd1,
        REG_SLICE_FULLY_REGISTERED = 2'd2
    } reg_slice_config_t;

    // ========================================================================
    // Default stream widths
    // ========================================================================

    // Number of data bytes per beat, with one tkeep bit per byte
    localparam int DEFAULT_DATA_BYTE_WID = 8;

    // Stream routing fields
    localparam int DEFAULT_TID_WID   = 4;
    localparam int DEFAULT_TDEST_WID = 4;

    // Sideband width. It must hold the byte count of the longest packet,
    // so 16 bits allows up to 65535 bytes
    localparam int DEFAULT_TUSER_WID = 16;

endpackage : axi4s_pkg

// File: axi4s_reg_slice.sv
// AXI4-Stream register slice in plain RTL, used on both sides of the pipeline.
// CONFIG picks bypass, a single-entry half-rate register or a full-rate skid
// buffer. All payload fields travel through the slice together as one beat.

`timescale 1ns/100ps

module axi4s_reg_slice
    import axi4s_pkg::*;
#(
    parameter int                DATA_BYTE_WID = DEFAULT_DATA_BYTE_WID,
    parameter int                TID_WID       = DEFAULT_TID_WID,
    parameter int                TDEST_WID     = DEFAULT_TDEST_WID,
    parameter int                TUSER_WID     = DEFAULT_TUSER_WID,
    parameter reg_slice_config_t CONFIG        = REG_SLICE_FULLY_REGISTERED
) (
    input  logic                       aclk,
    input  logic                       arst_n,
    // Sink side
    input  logic                       s_tvalid,
    output logic                       s_tready,
    input  logic [DATA_BYTE_WID*8-1:0] s_tdata,
    input  logic [DATA_BYTE_WID-1:0]   s_tkeep,
    input  logic                       s_tlast,
    input  logic [TID_WID-1:0]         s_tid,
    input  logic [TDEST_WID-1:0]       s_tdest,
    input  logic [TUSER_WID-1:0]       s_tuser,
    // Source side
    output logic                       m_tvalid,
    input  logic                       m_tready,
    output logic [DATA_BYTE_WID*8-1:0] m_tdata,
    output logic [DATA_BYTE_WID-1:0]   m_tkeep,
    output logic                       m_tlast,
    output logic [TID_WID-1:0]         m_tid,
    output logic [TDEST_WID-1:0]       m_tdest,
    output logic [TUSER_WID-1:0]       m_tuser
);

    // Width of one beat with every payload field packed side by side
    localparam int BEAT_WID = DATA_BYTE_WID * 8 + DATA_BYTE_WID + 1
                              + TID_WID + TDEST_WID + TUSER_WID;

    logic [BEAT_WID-1:0] s_beat;
    logic [BEAT_WID-1:0] m_beat;

    assign s_beat = {s_tdata, s_tkeep, s_tlast, s_tid, s_tdest, s_tuser};
    assign {m_tdata, m_tkeep, m_tlast, m_tid, m_tdest, m_tuser} = m_beat;

    if (CONFIG == REG_SLICE_BYPASS) begin : g_bypass

        // ====================================================================
        // Bypass: no storage, the handshake passes straight through
        // ====================================================================
        assign m_tvalid = s_tvalid;
        assign s_tready = m_tready;
        assign m_beat   = s_beat;

    end else if (CONFIG == REG_SLICE_LIGHTWEIGHT) begin : g_lightweight

        // ====================================================================
        // Lightweight: one beat register and a full flag
        // ====================================================================
        logic                full_q;
        logic [BEAT_WID-1:0] beat_q;
        logic                accept;
        logic                drain;

        // Only an empty register takes a beat, so a beat can never enter on
        // the same cycle that one leaves and the rate drops to one in two
        assign s_tready = !full_q;
        assign accept   = s_tvalid && !full_q;
        assign drain    = full_q && m_tready;

        always_ff @(posedge aclk or negedge arst_n) begin
            if (!arst_n) begin
                full_q <= 1'b0;
            end else if (accept) begin
                full_q <= 1'b1;
            end else if (drain) begin
                full_q <= 1'b0;
            end
        end

        always_ff @(posedge aclk) begin
            if (accept) begin
                beat_q <= s_beat;
            end
        end

        assign m_tvalid = full_q;
        assign m_beat   = beat_q;

    end else begin : g_fully_registered

        // ====================================================================
        // Fully registered: main register plus skid entry
        // ====================================================================
        logic                main_valid_q;
        logic                main_valid_d;
        logic                skid_valid_q;
        logic                skid_valid_d;
        logic                s_ready_q;
        logic [BEAT_WID-1:0] main_beat_q;
        logic [BEAT_WID-1:0] skid_beat_q;
        logic                s_xfer;
        logic                main_load;

        assign s_xfer    = s_tvalid && s_ready_q;
        // Main register can take a new beat when it is empty or draining
        assign main_load = !main_valid_q || m_tready;

        always_comb begin
            main_valid_d = main_valid_q;
            skid_valid_d = skid_valid_q;
            if (main_load) begin
                // Skid entry goes first to keep order. It is never full while
                // s_ready_q is high, so both sources cannot be live at once
                main_valid_d = skid_valid_q || s_xfer;
                skid_valid_d = 1'b0;
            end else if (s_xfer) begin
                // Beat in flight while the output stalls lands in the skid
                skid_valid_d = 1'b1;
            end
        end

        always_ff @(posedge aclk or negedge arst_n) begin
            if (!arst_n) begin
                main_valid_q <= 1'b0;
                skid_valid_q <= 1'b0;
                s_ready_q    <= 1'b0;
            end else begin
                main_valid_q <= main_valid_d;
                skid_valid_q <= skid_valid_d;
                // Ready follows the skid state, so it drops the cycle after a
                // beat is parked and rises one cycle after reset release
                s_ready_q    <= !skid_valid_d;
            end
        end

        always_ff @(posedge aclk) begin
            if (main_load && (skid_valid_q || s_xfer)) begin
                main_beat_q <= skid_valid_q ? skid_beat_q : s_beat;
            end
            if (!main_load && s_xfer) begin
                skid_beat_q <= s_beat;
            end
        end

        assign s_tready = s_ready_q;
        assign m_tvalid = main_valid_q;
        assign m_beat   = main_beat_q;

    end

endmodule : axi4s_reg_slice

// File: axi4s_pkt_length.sv
// Packet length stage for the AXI4-Stream pipeline.
// Counts the valid bytes of each packet from tkeep and places the total in
// tuser on the last beat. The data path is combinational with zero latency.

`timescale 1ns/100ps

module axi4s_pkt_length
    import axi4s_pkg::*;
#(
    parameter int DATA_BYTE_WID = DEFAULT_DATA_BYTE_WID,
    parameter int TID_WID       = DEFAULT_TID_WID,
    parameter int TDEST_WID     = DEFAULT_TDEST_WID,
    parameter int TUSER_WID     = DEFAULT_TUSER_WID
) (
    input  logic                       aclk,
    input  logic                       arst_n,
    // Sink side, tuser is generated here so there is no input for it
    input  logic                       s_tvalid,
    output logic                       s_tready,
    input  logic [DATA_BYTE_WID*8-1:0] s_tdata,
    input  logic [DATA_BYTE_WID-1:0]   s_tkeep,
    input  logic                       s_tlast,
    input  logic [TID_WID-1:0]         s_tid,
    input  logic [TDEST_WID-1:0]       s_tdest,
    // Source side
    output logic                       m_tvalid,
    input  logic                       m_tready,
    output logic [DATA_BYTE_WID*8-1:0] m_tdata,
    output logic [DATA_BYTE_WID-1:0]   m_tkeep,
    output logic                       m_tlast,
    output logic [TID_WID-1:0]         m_tid,
    output logic [TDEST_WID-1:0]       m_tdest,
    output logic [TUSER_WID-1:0]       m_tuser
);

    // Number of set tkeep bits, sized to add straight onto the packet count
    function automatic logic [TUSER_WID-1:0] count_keep(
        input logic [DATA_BYTE_WID-1:0] keep
    );
        logic [TUSER_WID-1:0] total;
        total = '0;
        for (int i = 0; i < DATA_BYTE_WID; i++) begin
            total = total + TUSER_WID'(keep[i]);
        end
        return total;
    endfunction

    logic [TUSER_WID-1:0] byte_count_q;
    logic [TUSER_WID-1:0] beat_bytes;
    logic [TUSER_WID-1:0] pkt_total;
    logic                 xfer;

    assign beat_bytes = count_keep(s_tkeep);
    // Total including the beat now on the bus, only meaningful on tlast
    assign pkt_total  = byte_count_q + beat_bytes;
    assign xfer       = s_tvalid && m_tready;

    // ========================================================================
    // Running byte count
    // ========================================================================

    // Only advances on a real transfer, so a stalled beat is counted once.
    // The count restarts from zero after the last beat of every packet
    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            byte_count_q <= '0;
        end else if (xfer) begin
            byte_count_q <= s_tlast ? '0 : pkt_total;
        end
    end

    // Handshake and payload pass through untouched
    assign s_tready = m_tready;
    assign m_tvalid = s_tvalid;
    assign m_tdata  = s_tdata;
    assign m_tkeep  = s_tkeep;
    assign m_tlast  = s_tlast;
    assign m_tid    = s_tid;
    assign m_tdest  = s_tdest;

    // Zero on every beat but the last one of a packet
    assign m_tuser  = s_tlast ? pkt_total : '0;

endmodule : axi4s_pkt_length

// File: axi4s_pipeline_top.sv
// Top level of the AXI4-Stream pipeline.
// Input register slice, packet length stage and output register slice in a
// chain. Each slice mode is set by its own parameter.

`timescale 1ns/100ps

module axi4s_pipeline_top
    import axi4s_pkg::*;
#(
    parameter int                DATA_BYTE_WID = DEFAULT_DATA_BYTE_WID,
    parameter int                TID_WID       = DEFAULT_TID_WID,
    parameter int                TDEST_WID     = DEFAULT_TDEST_WID,
    parameter int                TUSER_WID     = DEFAULT_TUSER_WID,
    parameter reg_slice_config_t CONFIG_IN     = REG_SLICE_FULLY_REGISTERED,
    parameter reg_slice_config_t CONFIG_OUT    = REG_SLICE_FULLY_REGISTERED
) (
    input  logic                       aclk,
    input  logic                       arst_n,
    // Sink side
    input  logic                       s_tvalid,
    output logic                       s_tready,
    input  logic [DATA_BYTE_WID*8-1:0] s_tdata,
    input  logic [DATA_BYTE_WID-1:0]   s_tkeep,
    input  logic                       s_tlast,
    input  logic [TID_WID-1:0]         s_tid,
    input  logic [TDEST_WID-1:0]       s_tdest,
    // Source side, tuser carries the packet byte count on the last beat
    output logic                       m_tvalid,
    input  logic                       m_tready,
    output logic [DATA_BYTE_WID*8-1:0] m_tdata,
    output logic [DATA_BYTE_WID-1:0]   m_tkeep,
    output logic                       m_tlast,
    output logic [TID_WID-1:0]         m_tid,
    output logic [TDEST_WID-1:0]       m_tdest,
    output logic [TUSER_WID-1:0]       m_tuser
);

    // Input slice to length stage
    logic                       in_tvalid;
    logic                       in_tready;
    logic [DATA_BYTE_WID*8-1:0] in_tdata;
    logic [DATA_BYTE_WID-1:0]   in_tkeep;
    logic                       in_tlast;
    logic [TID_WID-1:0]         in_tid;
    logic [TDEST_WID-1:0]       in_tdest;

    // Length stage to output slice
    logic                       mid_tvalid;
    logic                       mid_tready;
    logic [DATA_BYTE_WID*8-1:0] mid_tdata;
    logic [DATA_BYTE_WID-1:0]   mid_tkeep;
    logic                       mid_tlast;
    logic [TID_WID-1:0]         mid_tid;
    logic [TDEST_WID-1:0]       mid_tdest;
    logic [TUSER_WID-1:0]       mid_tuser;

    // Stream has no tuser yet at this point. The zero field is left open on
    // the far side and trimmed away in synthesis
    axi4s_reg_slice #(
        .DATA_BYTE_WID ( DATA_BYTE_WID ),
        .TID_WID       ( TID_WID ),
        .TDEST_WID     ( TDEST_WID ),
        .TUSER_WID     ( TUSER_WID ),
        .CONFIG        ( CONFIG_IN )
    ) u_slice_in (
        .aclk     ( aclk ),       .arst_n   ( arst_n ),
        .s_tvalid ( s_tvalid ),   .s_tready ( s_tready ),
        .s_tdata  ( s_tdata ),    .s_tkeep  ( s_tkeep ),
        .s_tlast  ( s_tlast ),    .s_tid    ( s_tid ),
        .s_tdest  ( s_tdest ),    .s_tuser  ( '0 ),
        .m_tvalid ( in_tvalid ),  .m_tready ( in_tready ),
        .m_tdata  ( in_tdata ),   .m_tkeep  ( in_tkeep ),
        .m_tlast  ( in_tlast ),   .m_tid    ( in_tid ),
        .m_tdest  ( in_tdest ),   .m_tuser  ( )
    );

    axi4s_pkt_length #(
        .DATA_BYTE_WID ( DATA_BYTE_WID ),
        .TID_WID       ( TID_WID ),
        .TDEST_WID     ( TDEST_WID ),
        .TUSER_WID     ( TUSER_WID )
    ) u_pkt_length (
        .aclk     ( aclk ),       .arst_n   ( arst_n ),
        .s_tvalid ( in_tvalid ),  .s_tready ( in_tready ),
        .s_tdata  ( in_tdata ),   .s_tkeep  ( in_tkeep ),
        .s_tlast  ( in_tlast ),   .s_tid    ( in_tid ),
        .s_tdest  ( in_tdest ),
        .m_tvalid ( mid_tvalid ), .m_tready ( mid_tready ),
        .m_tdata  ( mid_tdata ),  .m_tkeep  ( mid_tkeep ),
        .m_tlast  ( mid_tlast ),  .m_tid    ( mid_tid ),
        .m_tdest  ( mid_tdest ),  .m_tuser  ( mid_tuser )
    );

    axi4s_reg_slice #(
        .DATA_BYTE_WID ( DATA_BYTE_WID ),
        .TID_WID       ( TID_WID ),
        .TDEST_WID     ( TDEST_WID ),
        .TUSER_WID     ( TUSER_WID ),
        .CONFIG        ( CONFIG_OUT )
    ) u_slice_out (
        .aclk     ( aclk ),       .arst_n   ( arst_n ),
        .s_tvalid ( mid_tvalid ), .s_tready ( mid_tready ),
        .s_tdata  ( mid_tdata ),  .s_tkeep  ( mid_tkeep ),
        .s_tlast  ( mid_tlast ),  .s_tid    ( mid_tid ),
        .s_tdest  ( mid_tdest ),  .s_tuser  ( mid_tuser ),
        .m_tvalid ( m_tvalid ),   .m_tready ( m_tready ),
        .m_tdata  ( m_tdata ),    .m_tkeep  ( m_tkeep ),
        .m_tlast  ( m_tlast ),    .m_tid    ( m_tid ),
        .m_tdest  ( m_tdest ),    .m_tuser  ( m_tuser )
    );

endmodule : axi4s_pipeline_top

// File: axi4s_pipeline_checker.sv
// Assertions on the output stream of the AXI4-Stream pipeline top level.
// The bind at the end attaches one instance to every axi4s_pipeline_top.

`timescale 1ns/100ps

module axi4s_pipeline_checker
    import axi4s_pkg::*;
#(
    parameter int DATA_BYTE_WID = DEFAULT_DATA_BYTE_WID,
    parameter int TID_WID       = DEFAULT_TID_WID,
    parameter int TDEST_WID     = DEFAULT_TDEST_WID,
    parameter int TUSER_WID     = DEFAULT_TUSER_WID
) (
    input logic                       aclk,
    input logic                       arst_n,
    input logic                       m_tvalid,
    input logic                       m_tready,
    input logic [DATA_BYTE_WID*8-1:0] m_tdata,
    input logic [DATA_BYTE_WID-1:0]   m_tkeep,
    input logic                       m_tlast,
    input logic [TID_WID-1:0]         m_tid,
    input logic [TDEST_WID-1:0]       m_tdest,
    input logic [TUSER_WID-1:0]       m_tuser
);

    // Number of assertion failures seen so far
    int fail_cnt = 0;

    logic [DATA_BYTE_WID*9+TID_WID+TDEST_WID+TUSER_WID:0] payload;

    assign payload = {m_tdata, m_tkeep, m_tlast, m_tid, m_tdest, m_tuser};

    // A stalled beat must stay on the bus unchanged until it is taken
    a_stall_hold: assert property (
        @(posedge aclk) disable iff (!arst_n)
        m_tvalid && !m_tready |=> m_tvalid && $stable(payload)
    ) else begin
        fail_cnt++;
        $error("output beat dropped or changed while m_tready was low");
    end

    a_reset_idle: assert property (@(posedge aclk) !arst_n |-> !m_tvalid) else begin
        fail_cnt++;
        $error("m_tvalid high while arst_n is low");
    end

    // Byte count only rides on the last beat of a packet
    a_tuser_zero: assert property (
        @(posedge aclk) disable iff (!arst_n)
        m_tvalid && !m_tlast |-> m_tuser == '0
    ) else begin
        fail_cnt++;
        $error("m_tuser not zero on a beat that is not the last");
    end

endmodule : axi4s_pipeline_checker

bind axi4s_pipeline_top axi4s_pipeline_checker #(
    .DATA_BYTE_WID ( DATA_BYTE_WID ),
    .TID_WID       ( TID_WID ),
    .TDEST_WID     ( TDEST_WID ),
    .TUSER_WID     ( TUSER_WID )
) u_checker (
    .aclk     ( aclk ),     .arst_n   ( arst_n ),
    .m_tvalid ( m_tvalid ), .m_tready ( m_tready ),
    .m_tdata  ( m_tdata ),  .m_tkeep  ( m_tkeep ),
    .m_tlast  ( m_tlast ),  .m_tid    ( m_tid ),
    .m_tdest  ( m_tdest ),  .m_tuser  ( m_tuser )
);

// File: tb_axi4s_pipeline.sv
// Testbench for the AXI4-Stream pipeline with a lightweight input slice and a
// fully registered output slice. Beats and expected tuser come from the golden
// file; runs cover reset, a clean stream, throughput and random back-pressure.

`timescale 1ns/100ps

module tb_axi4s_pipeline
    import axi4s_pkg::*;
();

    localparam int NUM_BEATS      = 27;
    localparam int GOLDEN_WID     = 100;
    localparam int STREAM_TIMEOUT = 2000;
    localparam int IDLE_CYCLES    = 6;
    localparam int WINDOW         = 20;

    logic                               aclk;
    logic                               arst_n;
    logic                               s_tvalid;
    logic                               s_tready;
    logic [DEFAULT_DATA_BYTE_WID*8-1:0] s_tdata;
    logic [DEFAULT_DATA_BYTE_WID-1:0]   s_tkeep;
    logic                               s_tlast;
    logic [DEFAULT_TID_WID-1:0]         s_tid;
    logic [DEFAULT_TDEST_WID-1:0]       s_tdest;
    logic                               m_tvalid;
    logic                               m_tready;
    logic [DEFAULT_DATA_BYTE_WID*8-1:0] m_tdata;
    logic [DEFAULT_DATA_BYTE_WID-1:0]   m_tkeep;
    logic                               m_tlast;
    logic [DEFAULT_TID_WID-1:0]         m_tid;
    logic [DEFAULT_TDEST_WID-1:0]       m_tdest;
    logic [DEFAULT_TUSER_WID-1:0]       m_tuser;

    // Golden word is tdata[99:36] tkeep[35:28] tlast[24] tid[23:20]
    // tdest[19:16] and expected tuser[15:0]
    logic [GOLDEN_WID-1:0] golden [0:NUM_BEATS-1];
    logic [31:0]           lfsr_q;
    int                    win_beats;
    int                    min_gap;
    int                    tests_run;
    int                    tests_failed;
    int                    reset_errs;
    int                    data_errs;
    int                    user_errs;
    int                    rate_errs;
    int                    bp_data_errs;
    int                    bp_user_errs;
    int                    assert_errs;

    always #5 aclk = ~aclk;

    axi4s_pipeline_top #(
        .CONFIG_IN  ( REG_SLICE_LIGHTWEIGHT ),
        .CONFIG_OUT ( REG_SLICE_FULLY_REGISTERED )
    ) u_axi4s_pipeline_top (
        .aclk     ( aclk ),     .arst_n   ( arst_n ),
        .s_tvalid ( s_tvalid ), .s_tready ( s_tready ),
        .s_tdata  ( s_tdata ),  .s_tkeep  ( s_tkeep ),
        .s_tlast  ( s_tlast ),  .s_tid    ( s_tid ),
        .s_tdest  ( s_tdest ),
        .m_tvalid ( m_tvalid ), .m_tready ( m_tready ),
        .m_tdata  ( m_tdata ),  .m_tkeep  ( m_tkeep ),
        .m_tlast  ( m_tlast ),  .m_tid    ( m_tid ),
        .m_tdest  ( m_tdest ),  .m_tuser  ( m_tuser )
    );

    // ========================================================================
    // Helpers
    // ========================================================================

    // Galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] galois_step(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
    endfunction

    task automatic take_random_bit(output logic rnd);
        lfsr_q = galois_step(lfsr_q);
        rnd    = lfsr_q[0];
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual, inout int errs);
        if (actual !== expected) begin
            $display("[FAIL] %s: expected %0h, actual %0h", name, expected, actual);
            errs++;
        end
    endtask

    task automatic report_test(input string name, input int errs);
        tests_run++;
        if (errs == 0) begin
            $display("test %-12s ok", name);
        end else begin
            $display("test %-12s %0d errors", name, errs);
            tests_failed++;
        end
    endtask

    // Streams the whole golden file through the DUT. Source and sink share one
    // loop so random bits are always drawn in the same order
    task automatic run_stream(input logic random_flow, input string data_name,
                              input string user_name, inout int data_err_cnt,
                              inout int user_err_cnt);
        logic [GOLDEN_WID-1:0] g;
        logic                  rnd;
        int                    sent;
        int                    got;
        int                    cyc;
        int                    first_cyc;
        int                    last_cyc;
        sent      = 0;
        got       = 0;
        cyc       = 0;
        first_cyc = 0;
        last_cyc  = 0;
        win_beats = 0;
        min_gap   = STREAM_TIMEOUT;
        while (got < NUM_BEATS && cyc < STREAM_TIMEOUT) begin
            @(posedge aclk);
            cyc++;
            // Output beat taken at this edge
            if (m_tvalid && m_tready) begin
                g = golden[got];
                check_value({data_name, " tdata"}, g[99:36], m_tdata, data_err_cnt);
                check_value({data_name, " tkeep"}, g[35:28], m_tkeep, data_err_cnt);
                check_value({data_name, " tlast"}, g[24], m_tlast, data_err_cnt);
                check_value({data_name, " tid"}, g[23:20], m_tid, data_err_cnt);
                check_value({data_name, " tdest"}, g[19:16], m_tdest, data_err_cnt);
                check_value({user_name, " tuser"}, g[15:0], m_tuser, user_err_cnt);
                if (got == 0) begin
                    first_cyc = cyc;
                end else if (cyc - last_cyc < min_gap) begin
                    min_gap = cyc - last_cyc;
                end
                if (cyc - first_cyc < WINDOW) begin
                    win_beats++;
                end
                last_cyc = cyc;
                got++;
            end
            if (s_tvalid && s_tready) begin
                sent++;
            end
            // A beat still waiting for s_tready is held as it is
            if (!s_tvalid || s_tready) begin
                rnd = 1'b1;
                if (random_flow) begin
                    take_random_bit(rnd);
                end
                if (sent < NUM_BEATS && rnd) begin
                    g = golden[sent];
                    s_tvalid <= 1'b1;
                    s_tdata  <= g[99:36];
                    s_tkeep  <= g[35:28];
                    s_tlast  <= g[24];
                    s_tid    <= g[23:20];
                    s_tdest  <= g[19:16];
                end else begin
                    s_tvalid <= 1'b0;
                end
            end
            rnd = 1'b1;
            if (random_flow) begin
                take_random_bit(rnd);
            end
            m_tready <= rnd;
        end
        if (got < NUM_BEATS) begin
            $display("Timeout in %s run: only %0d of %0d beats came out of the DUT",
                     data_name, got, NUM_BEATS);
            data_err_cnt++;
        end
        s_tvalid <= 1'b0;
        m_tready <= 1'b1;
        // Every golden beat is out, so any further beat is a duplicate
        repeat (IDLE_CYCLES) begin
            @(posedge aclk);
            check_value({data_name, " extra beat"}, 0, m_tvalid, data_err_cnt);
        end
    endtask

    // ========================================================================
    // Test sequence
    // ========================================================================

    initial begin
        aclk         = 1'b0;
        arst_n       = 1'b1;
        s_tvalid     = 1'b0;
        s_tdata      = '0;
        s_tkeep      = '0;
        s_tlast      = 1'b0;
        s_tid        = '0;
        s_tdest      = '0;
        m_tready     = 1'b0;
        lfsr_q       = 32'h10766ee6;
        tests_run    = 0;
        tests_failed = 0;
        reset_errs   = 0;
        data_errs    = 0;
        user_errs    = 0;
        rate_errs    = 0;
        bp_data_errs = 0;
        bp_user_errs = 0;
        assert_errs  = 0;
        $readmemh("axi4s_golden.txt", golden);
        if ($isunknown(golden[NUM_BEATS-1])) begin
            $display("Golden file axi4s_golden.txt is missing or has too few beats");
            data_errs++;
        end

        // Reset drops just after time zero so every flop sees a falling edge
        #1 arst_n = 1'b0;
        repeat (4) @(posedge aclk);
        check_value("reset m_tvalid", 0, m_tvalid, reset_errs);
        arst_n   <= 1'b1;
        m_tready <= 1'b1;
        // Idle source, so nothing may come out
        repeat (IDLE_CYCLES) begin
            @(posedge aclk);
            check_value("reset m_tvalid", 0, m_tvalid, reset_errs);
        end
        // Empty lightweight input slice is ready
        check_value("reset s_tready", 1, s_tready, reset_errs);
        report_test("reset", reset_errs);

        run_stream(1'b0, "integrity", "pkt_length", data_errs, user_errs);
        report_test("integrity", data_errs);
        report_test("pkt_length", user_errs);

        // Lightweight input slice spaces the beats two cycles apart
        check_value("throughput window beats", WINDOW / 2, win_beats, rate_errs);
        check_value("throughput min beat gap", 2, min_gap, rate_errs);
        report_test("throughput", rate_errs);

        run_stream(1'b1, "backpressure", "backpressure", bp_data_errs, bp_user_errs);
        report_test("backpressure", bp_data_errs + bp_user_errs);

        check_value("assertion failures", 0, u_axi4s_pipeline_top.u_checker.fail_cnt,
                    assert_errs);
        report_test("assertions", assert_errs);

        $display("Tests run: %0d, failed: %0d", tests_run, tests_failed);
        if (tests_failed == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule : tb_axi4s_pipeline

// File: axi4s_golden.txt
// tdata (64 bit) _ tkeep _ tlast _ tid _ tdest _ expected tuser (16 bit), one input beat per line
// Expected tuser is the packet byte count on a last beat and zero on every other beat
1001_a0a0_0000_0001_ff_0_1_2_0000
1001_a0a0_0000_0002_ff_0_1_2_0000
1001_a0a0_0000_0003_ff_1_1_2_0018
2002_b1b1_0000_0004_0f_1_2_3_0004
3003_c2c2_0000_0005_ff_0_3_4_0000
3003_c2c2_0000_0006_ff_0_3_4_0000
3003_c2c2_0000_0007_ff_0_3_4_0000
3003_c2c2_0000_0008_07_1_3_4_001b
4004_d3d3_0000_0009_ff_1_4_5_0008
5005_e4e4_0000_000a_ff_0_5_6_0000
5005_e4e4_0000_000b_01_1_5_6_0009
6006_f5f5_0000_000c_ff_0_6_7_0000
6006_f5f5_0000_000d_ff_0_6_7_0000
6006_f5f5_0000_000e_ff_0_6_7_0000
6006_f5f5_0000_000f_ff_0_6_7_0000
6006_f5f5_0000_0010_ff_0_6_7_0000
6006_f5f5_0000_0011_3f_1_6_7_002e
7007_0606_0000_0012_5a_1_7_8_0004
8008_1717_0000_0013_ff_0_8_9_0000
8008_1717_0000_0014_ff_0_8_9_0000
8008_1717_0000_0015_7f_1_8_9_0017
9009_2828_0000_0016_ff_0_9_a_0000
9009_2828_0000_0017_ff_0_9_a_0000
9009_2828_0000_0018_ff_0_9_a_0000
9009_2828_0000_0019_ff_0_9_a_0000
9009_2828_0000_001a_1f_1_9_a_0025
a00a_3939_0000_001b_03_1_a_b_0002

// File: tb.f
axi4s_pkg.sv
axi4s_reg_slice.sv
axi4s_pkt_length.sv
axi4s_pipeline_top.sv
axi4s_pipeline_checker.sv
tb_axi4s_pipeline.sv

// File: Bender.yml
package:
  name: axi4s_pipeline

sources:
  - axi4s_pkg.sv
  - axi4s_reg_slice.sv
  - axi4s_pkt_length.sv
  - axi4s_pipeline_top.sv
  - target: test
    files:
      - axi4s_pipeline_checker.sv
      - tb_axi4s_pipeline.sv
